// ==== files.f ====
design/lsu_ahb_pkg.sv
design/ahb_xfer_fsm.sv
design/ahb_addr_phase.sv
design/ahb_rdata_hold.sv
design/lsu_ahb_master.sv
test/tb_lsu_ahb_master.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ns
TOP      = tb_lsu_ahb_master
FILELIST = files.f
OBJ_DIR  = obj_dir
PASS_MSG = Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== test/tb_lsu_ahb_master.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_lsu_ahb_master;

    import lsu_ahb_pkg::*;

    localparam int          NUM_OPS        = 300;
    localparam int          MEM_WORDS      = 16;
    localparam int          TIMEOUT_CYCLES = NUM_OPS * 14 + 50;
    localparam logic [31:0] SEED           = 32'h5f39116d;
    localparam logic [31:0] WIN_BASE       = 32'h1000_0000;

    logic              clk;
    logic              rst_n;
    logic              re_i;
    logic              we_i;
    logic [ADDR_W-1:0] addr_i;
    logic [DATA_W-1:0] wdata_i;
    logic [DATA_W-1:0] rdata_o;
    logic              flush_i;
    logic              wb_stall_i;
    logic              stallreq_o;
    logic              hsel_o;
    htrans_e           htrans_o;
    logic [ADDR_W-1:0] haddr_o;
    logic              hwrite_o;
    logic [DATA_W-1:0] hwdata_o;
    logic              hready_i;
    logic [DATA_W-1:0] hrdata_i;

    // slave memory and the reference copy
    logic [DATA_W-1:0] slave_mem [0:MEM_WORDS-1];
    logic [DATA_W-1:0] model_mem [0:MEM_WORDS-1];

    // slave data phase tracking
    logic       s_busy;
    logic       s_wr;
    logic [3:0] s_idx;
    int         s_wait;
    logic       acc_now;
    logic       cmp_now;
    logic       acc_wr;
    logic [3:0] acc_idx;

    // request currently presented by the lsu
    int                cur_waits;
    logic [ADDR_W-1:0] cur_addr;
    logic [DATA_W-1:0] cur_wdata;

    logic [31:0] rng;
    int          cyc;
    int          checks;
    int          errors;

    lsu_ahb_master u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .re_i       (re_i),
        .we_i       (we_i),
        .addr_i     (addr_i),
        .wdata_i    (wdata_i),
        .rdata_o    (rdata_o),
        .flush_i    (flush_i),
        .wb_stall_i (wb_stall_i),
        .stallreq_o (stallreq_o),
        .hsel_o     (hsel_o),
        .htrans_o   (htrans_o),
        .haddr_o    (haddr_o),
        .hwrite_o   (hwrite_o),
        .hwdata_o   (hwdata_o),
        .hready_i   (hready_i),
        .hrdata_i   (hrdata_i)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cyc = 0;
        while (cyc < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cyc = cyc + 1;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // called at the falling edge, looks ahead to the next rising edge
    task automatic sample_bus();
        acc_now = (htrans_o == HTRANS_NONSEQ) && hready_i;
        cmp_now = s_busy && hready_i;
        acc_wr  = hwrite_o;
        acc_idx = haddr_o[5:2];
        if (s_busy && s_wr) begin
            check_value("hwdata_o", hwdata_o, cur_wdata);
        end
        if (cmp_now && s_wr) begin
            slave_mem[s_idx] = hwdata_o;
        end
    endtask

    task automatic drive_slave();
        if (cmp_now) begin
            s_busy = 1'b0;
        end
        if (acc_now) begin
            s_busy = 1'b1;
            s_wr   = acc_wr;
            s_idx  = acc_idx;
            s_wait = cur_waits;
        end
        if (s_busy && s_wait > 0) begin
            hready_i = 1'b0;
            s_wait   = s_wait - 1;
        end else begin
            hready_i = 1'b1;
        end
        hrdata_i = (s_busy && !s_wr) ? slave_mem[s_idx] : 32'hdead_beef;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
        drive_slave();
    endtask

    task automatic idle_cycle(input logic with_flush);
        re_i       = 1'b0;
        we_i       = 1'b0;
        flush_i    = with_flush;
        wb_stall_i = 1'b0;
        @(negedge clk);
        sample_bus();
        check_value("stallreq_o", 32'(stallreq_o), 32'd0);
        check_value("hsel_o", 32'(hsel_o), 32'd0);
        check_value("rdata_o", rdata_o, 32'd0);
        next_cycle();
    endtask

    task automatic run_op();
        logic              is_wr;
        logic [3:0]        idx;
        logic [DATA_W-1:0] exp_rdata;
        int                waits;
        int                stalls;
        int                stall_total;
        int                flushes;
        int                start_cyc;
        logic              done_seen;
        logic              consumed;
        logic              addr_cyc;

        rng = xorshift(rng);
        is_wr       = rng[0];
        idx         = rng[7:4];
        waits       = int'(rng[9:8]);
        stall_total = int'(rng[11:10]);
        flushes     = (rng[14:12] == 3'd0) ? 1 + int'(rng[15]) : 0;
        // about one op in four on the zero-wait, unstalled path
        if (rng[17:16] == 2'd0) begin
            waits       = 0;
            stall_total = 0;
        end
        rng = xorshift(rng);
        cur_wdata = rng;
        cur_waits = waits;
        cur_addr  = WIN_BASE + {26'd0, idx, 2'b00};
        exp_rdata = is_wr ? 32'd0 : model_mem[idx];
        stalls    = stall_total;

        re_i    = !is_wr;
        we_i    = is_wr;
        addr_i  = cur_addr;
        wdata_i = cur_wdata;

        start_cyc = -1;
        done_seen = 1'b0;
        consumed  = 1'b0;
        while (!consumed) begin
            flush_i = (flushes > 0);
            if (s_busy && hready_i) begin
                done_seen = 1'b1;
            end
            wb_stall_i = done_seen && (stalls > 0);
            @(negedge clk);
            sample_bus();
            if (start_cyc < 0 && !flush_i) begin
                start_cyc = cyc;
            end
            // the address phase shows exactly one cycle after the start
            addr_cyc = (start_cyc >= 0) && (cyc == start_cyc + 1);
            check_value("hsel_o", 32'(hsel_o), 32'(addr_cyc));
            check_value("htrans_o", 32'(htrans_o),
                        32'(addr_cyc ? HTRANS_NONSEQ : HTRANS_IDLE));
            if (addr_cyc) begin
                check_value("haddr_o", haddr_o, cur_addr);
                check_value("hwrite_o", 32'(hwrite_o), 32'(is_wr));
            end
            if (flush_i) begin
                check_value("stallreq_o", 32'(stallreq_o), 32'd0);
            end
            if (wb_stall_i) begin
                check_value("stallreq_o", 32'(stallreq_o), 32'd1);
                check_value("rdata_o", rdata_o, exp_rdata);
            end
            consumed = !flush_i && !stallreq_o;
            if (!consumed) begin
                if (flushes > 0) begin
                    flushes = flushes - 1;
                end
                if (wb_stall_i) begin
                    stalls = stalls - 1;
                end
                next_cycle();
            end
        end

        check_value("rdata_o", rdata_o, exp_rdata);
        check_value("consume_cycle", 32'(cyc), 32'(start_cyc + 2 + waits + stall_total));
        if (is_wr) begin
            model_mem[idx] = cur_wdata;
        end
        next_cycle();
        re_i       = 1'b0;
        we_i       = 1'b0;
        wb_stall_i = 1'b0;
    endtask

    initial begin
        rst_n      = 1'b0;
        re_i       = 1'b0;
        we_i       = 1'b0;
        addr_i     = '0;
        wdata_i    = '0;
        flush_i    = 1'b0;
        wb_stall_i = 1'b0;
        hready_i   = 1'b1;
        hrdata_i   = '0;
        s_busy     = 1'b0;
        s_wr       = 1'b0;
        s_idx      = '0;
        s_wait     = 0;
        acc_now    = 1'b0;
        cmp_now    = 1'b0;
        acc_wr     = 1'b0;
        acc_idx    = '0;
        cur_waits  = 0;
        cur_addr   = '0;
        cur_wdata  = '0;
        checks     = 0;
        errors     = 0;
        rng        = SEED;
        for (int i = 0; i < MEM_WORDS; i++) begin
            slave_mem[i] = (WIN_BASE + 32'(i * 4)) * 32'h9e3779b1;
            model_mem[i] = slave_mem[i];
        end

        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // idle outputs straight after reset
        @(negedge clk);
        sample_bus();
        check_value("hsel_o", 32'(hsel_o), 32'd0);
        check_value("hwrite_o", 32'(hwrite_o), 32'd0);
        check_value("haddr_o", haddr_o, 32'd0);
        check_value("htrans_o", 32'(htrans_o), 32'(HTRANS_IDLE));
        check_value("rdata_o", rdata_o, 32'd0);
        check_value("stallreq_o", 32'(stallreq_o), 32'd0);
        next_cycle();

        for (int n = 0; n < NUM_OPS; n++) begin
            rng = xorshift(rng);
            if (rng[2:0] == 3'd0) begin
                idle_cycle(rng[3]);
            end
            run_op();
        end
        idle_cycle(1'b0);

        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/lsu_ahb_master.sv ====
`timescale 1ns/1ns
`default_nettype none

module lsu_ahb_master (
    input  wire                              clk,
    input  wire                              rst_n,

    // lsu side
    input  wire                              re_i,
    input  wire                              we_i,
    input  wire  [lsu_ahb_pkg::ADDR_W-1:0]   addr_i,
    input  wire  [lsu_ahb_pkg::DATA_W-1:0]   wdata_i,
    output logic [lsu_ahb_pkg::DATA_W-1:0]   rdata_o,

    // pipeline control
    input  wire                              flush_i,
    input  wire                              wb_stall_i,
    output logic                             stallreq_o,

    // ahb-lite master
    output logic                             hsel_o,
    output lsu_ahb_pkg::htrans_e             htrans_o,
    output logic [lsu_ahb_pkg::ADDR_W-1:0]   haddr_o,
    output logic                             hwrite_o,
    output logic [lsu_ahb_pkg::DATA_W-1:0]   hwdata_o,
    input  wire                              hready_i,
    input  wire  [lsu_ahb_pkg::DATA_W-1:0]   hrdata_i
);

    wire start_rd;
    wire start_wr;
    wire addr_accept;
    wire rd_done;
    wire capture;
    wire hold_rd;

    ahb_xfer_fsm u_fsm (
        .clk           (clk),
        .rst_n         (rst_n),
        .re_i          (re_i),
        .we_i          (we_i),
        .flush_i       (flush_i),
        .wb_stall_i    (wb_stall_i),
        .hready_i      (hready_i),
        .start_rd_o    (start_rd),
        .start_wr_o    (start_wr),
        .addr_accept_o (addr_accept),
        .rd_done_o     (rd_done),
        .capture_o     (capture),
        .hold_rd_o     (hold_rd),
        .stallreq_o    (stallreq_o)
    );

    ahb_addr_phase u_addr (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_rd_i    (start_rd),
        .start_wr_i    (start_wr),
        .addr_accept_i (addr_accept),
        .addr_i        (addr_i),
        .wdata_i       (wdata_i),
        .hsel_o        (hsel_o),
        .htrans_o      (htrans_o),
        .haddr_o       (haddr_o),
        .hwrite_o      (hwrite_o),
        .hwdata_o      (hwdata_o)
    );

    ahb_rdata_hold u_rdata (
        .clk           (clk),
        .rst_n         (rst_n),
        .rd_done_i     (rd_done),
        .capture_i     (capture),
        .hold_rd_i     (hold_rd),
        .hrdata_i      (hrdata_i),
        .rdata_o       (rdata_o)
    );

endmodule

`default_nettype wire

// ==== design/ahb_rdata_hold.sv ====
`timescale 1ns/1ns
`default_nettype none

module ahb_rdata_hold (
    input  wire                              clk,
    input  wire                              rst_n,

    // strobes from the fsm
    input  wire                              rd_done_i,
    input  wire                              capture_i,
    input  wire                              hold_rd_i,

    input  wire  [lsu_ahb_pkg::DATA_W-1:0]   hrdata_i,

    output logic [lsu_ahb_pkg::DATA_W-1:0]   rdata_o
);

    import lsu_ahb_pkg::*;

    logic [DATA_W-1:0] hold_q;

    // keeps the completed read while writeback is stalled
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_q <= '0;
        end else if (capture_i) begin
            hold_q <= hrdata_i;
        end
    end

    // live bus data on completion, held word afterwards
    always_comb begin
        if (rd_done_i) begin
            rdata_o = hrdata_i;
        end else if (hold_rd_i) begin
            rdata_o = hold_q;
        end else begin
            rdata_o = '0;
        end
    end

    a_done_xor_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(rd_done_i && hold_rd_i)
    );

    // a hold is always preceded by a capture or another hold cycle
    a_hold_after_capture: assert property (
        @(posedge clk) disable iff (!rst_n)
        hold_rd_i |-> $past(capture_i || hold_rd_i)
    );

endmodule

`default_nettype wire

// ==== design/ahb_addr_phase.sv ====
`timescale 1ns/1ns
`default_nettype none

module ahb_addr_phase (
    input  wire                              clk,
    input  wire                              rst_n,

    // strobes from the fsm
    input  wire                              start_rd_i,
    input  wire                              start_wr_i,
    input  wire                              addr_accept_i,

    // lsu request payload
    input  wire  [lsu_ahb_pkg::ADDR_W-1:0]   addr_i,
    input  wire  [lsu_ahb_pkg::DATA_W-1:0]   wdata_i,

    // ahb master outputs
    output logic                             hsel_o,
    output lsu_ahb_pkg::htrans_e             htrans_o,
    output logic [lsu_ahb_pkg::ADDR_W-1:0]   haddr_o,
    output logic                             hwrite_o,
    output logic [lsu_ahb_pkg::DATA_W-1:0]   hwdata_o
);

    import lsu_ahb_pkg::*;

    logic start;

    assign start = start_rd_i || start_wr_i;

    // address phase control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hsel_o   <= 1'b0;
            htrans_o <= HTRANS_IDLE;
            haddr_o  <= '0;
            hwrite_o <= 1'b0;
        end else if (start) begin
            hsel_o   <= 1'b1;
            htrans_o <= HTRANS_NONSEQ;
            haddr_o  <= addr_i;
            hwrite_o <= start_wr_i;
        end else if (addr_accept_i) begin
            // hwrite kept, it belongs to the finished address phase
            hsel_o   <= 1'b0;
            htrans_o <= HTRANS_IDLE;
            haddr_o  <= '0;
        end
    end

    // write data lags the address by one phase
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hwdata_o <= '0;
        end else if (addr_accept_i && hwrite_o) begin
            hwdata_o <= wdata_i;
        end
    end

    // address and direction frozen while the slave holds off the address phase
    a_addr_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (htrans_o == HTRANS_NONSEQ && !addr_accept_i)
            |=> ($stable(haddr_o) && $stable(hwrite_o))
    );

    // no new start while an address phase is still on the bus
    a_no_restart: assert property (
        @(posedge clk) disable iff (!rst_n)
        (htrans_o == HTRANS_NONSEQ) |-> !start
    );

endmodule

`default_nettype wire

// ==== design/ahb_xfer_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module ahb_xfer_fsm (
    input  wire  clk,
    input  wire  rst_n,

    // lsu request
    input  wire  re_i,
    input  wire  we_i,

    // pipeline control
    input  wire  flush_i,
    input  wire  wb_stall_i,

    input  wire  hready_i,

    // to the address phase registers
    output logic start_rd_o,
    output logic start_wr_o,
    output logic addr_accept_o,

    // to the read data path
    output logic rd_done_o,
    output logic capture_o,
    output logic hold_rd_o,

    output logic stallreq_o
);

    import lsu_ahb_pkg::*;

    xfer_state_e state_q;
    xfer_state_e state_d;

    logic in_addr;
    logic in_data;
    logic data_done;

    assign in_addr   = (state_q == XS_ADDR_RD) || (state_q == XS_ADDR_WR);
    assign in_data   = (state_q == XS_DATA_RD) || (state_q == XS_DATA_WR);
    assign data_done = in_data && hready_i;

    // a new transfer only starts from idle, never under flush
    assign start_rd_o = (state_q == XS_IDLE) && re_i && hready_i && !flush_i;
    assign start_wr_o = (state_q == XS_IDLE) && we_i && hready_i && !flush_i;

    assign addr_accept_o = in_addr && hready_i;

    assign rd_done_o = (state_q == XS_DATA_RD) && hready_i;
    assign capture_o = rd_done_o && wb_stall_i;
    assign hold_rd_o = (state_q == XS_HOLD_RD);

    always_comb begin
        state_d = state_q;
        case (state_q)
            XS_IDLE: begin
                if (start_rd_o) begin
                    state_d = XS_ADDR_RD;
                end else if (start_wr_o) begin
                    state_d = XS_ADDR_WR;
                end
            end
            // bus phases run to the end, flush or not
            XS_ADDR_RD: begin
                if (hready_i) begin
                    state_d = XS_DATA_RD;
                end
            end
            XS_ADDR_WR: begin
                if (hready_i) begin
                    state_d = XS_DATA_WR;
                end
            end
            XS_DATA_RD: begin
                if (data_done) begin
                    state_d = wb_stall_i ? XS_HOLD_RD : XS_IDLE;
                end
            end
            XS_DATA_WR: begin
                if (data_done) begin
                    state_d = wb_stall_i ? XS_HOLD_WR : XS_IDLE;
                end
            end
            XS_HOLD_RD, XS_HOLD_WR: begin
                if (!wb_stall_i || flush_i) begin
                    state_d = XS_IDLE;
                end
            end
            default: begin
                state_d = XS_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= XS_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // pipeline waits until the fsm is headed back to idle
    assign stallreq_o = (state_d != XS_IDLE);

    // lsu never asks for both directions at once
    a_one_dir_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(re_i && we_i)
    );

    a_one_start: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(start_rd_o && start_wr_o)
    );

endmodule

`default_nettype wire

// ==== design/lsu_ahb_pkg.sv ====
`default_nettype none

package lsu_ahb_pkg;

    // one word of address and data on the bus
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // only the two transfer types a single-word master needs
    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_NONSEQ = 2'b10
    } htrans_e;

    // transfer progress, split by direction
    typedef enum logic [2:0] {
        XS_IDLE    = 3'd0,
        // address phase on the bus
        XS_ADDR_RD = 3'd1,
        XS_ADDR_WR = 3'd2,
        // data phase in progress
        XS_DATA_RD = 3'd3,
        XS_DATA_WR = 3'd4,
        // done, waiting for writeback
        XS_HOLD_RD = 3'd5,
        XS_HOLD_WR = 3'd6
    } xfer_state_e;

endpackage

`default_nettype wire
